/* hdl/hdc_settings.svh */
`ifndef HDC_SETTINGS_SVH
`define HDC_SETTINGS_SVH

// hypervector width in bits
`define HDC_DIM 32

// input lanes per stream beat
`define HDC_LANES 4

// xorshift32 start value, must be nonzero
`define HDC_SEED 32'h6c07_8965

// axi-lite address bits decoded
`define HDC_AXIL_AW 12

`endif

/* hdl/hdc_pkg.sv */
`include "hdc_settings.svh"
`default_nettype none

package hdc_pkg;

    // one hypervector
    typedef logic [`HDC_DIM-1:0] hv_t;

    // one input beat, lane i sits in bits 32i+31..32i
    typedef hv_t [`HDC_LANES-1:0] lanes_t;

    // item memory index
    typedef logic [15:0] item_idx_t;

endpackage

`default_nettype wire

/* hdl/axil_pkg.sv */
`include "hdc_settings.svh"
`default_nettype none

package axil_pkg;

    // register byte offsets
    typedef enum logic [`HDC_AXIL_AW-1:0] {
        REG_CTRL     = 'h000,
        REG_ITEM_SEL = 'h004
    } reg_off_e;

    // slave fsm states
    typedef enum logic [2:0] {
        IDLE,
        GOT_AW,
        GOT_W,
        RESP_B,
        READ_1,
        READ_2
    } axil_state_e;

endpackage

`default_nettype wire

/* hdl/hv_stream_if.sv */
`timescale 1ns/10ps
`default_nettype none

// valid/ready stream, payload type set per instance
interface hv_stream_if #(
    parameter type T = logic
);

    logic valid;
    logic ready;
    T     data;
    logic last;

    // producer side
    modport src (output valid, output data, output last, input ready);

    // consumer side
    modport dst (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

/* hdl/axil_regs.sv */
`include "hdc_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module axil_regs (
    input  wire                     AXIS_ACLK,
    input  wire                     S_AXI_ARESETN,
    input  wire [`HDC_AXIL_AW-1:0]  S_AXI_AWADDR,
    input  wire                     S_AXI_AWVALID,
    output logic                    S_AXI_AWREADY,
    input  wire [31:0]              S_AXI_WDATA,
    input  wire [3:0]               S_AXI_WSTRB,
    input  wire                     S_AXI_WVALID,
    output logic                    S_AXI_WREADY,
    output logic                    S_AXI_BVALID,
    input  wire                     S_AXI_BREADY,
    input  wire [`HDC_AXIL_AW-1:0]  S_AXI_ARADDR,
    input  wire                     S_AXI_ARVALID,
    output logic                    S_AXI_ARREADY,
    output logic [31:0]             S_AXI_RDATA,
    output logic                    S_AXI_RVALID,
    input  wire                     S_AXI_RREADY,
    input  wire                     gen_done,
    output logic                    run,
    output logic                    gen,
    output hdc_pkg::item_idx_t      item_sel
);

    import axil_pkg::*;

    axil_state_e             state_q;
    logic [`HDC_AXIL_AW-1:0] aw_addr_q;
    logic [`HDC_AXIL_AW-1:0] ar_addr_q;
    logic [31:0]             w_data_q;
    logic [3:0]              w_strb_q;

    logic                    aw_take;
    logic                    w_take;
    logic                    ar_take;
    logic                    wr_fire;
    logic [`HDC_AXIL_AW-1:0] wr_addr;
    logic [31:0]             wr_data;
    logic [3:0]              wr_strb;
    logic [31:0]             rd_word;

    // ====================
    // channel handshakes
    // ====================

    assign S_AXI_AWREADY = (state_q == IDLE) | (state_q == GOT_W);
    assign S_AXI_WREADY  = (state_q == IDLE) | (state_q == GOT_AW);
    // writes win in idle, read waits until both write channels are quiet
    assign S_AXI_ARREADY = (state_q == IDLE) & ~S_AXI_AWVALID & ~S_AXI_WVALID;
    assign S_AXI_BVALID  = (state_q == RESP_B);
    assign S_AXI_RVALID  = (state_q == READ_2);

    assign aw_take = S_AXI_AWVALID & S_AXI_AWREADY;
    assign w_take  = S_AXI_WVALID & S_AXI_WREADY;
    assign ar_take = S_AXI_ARVALID & S_AXI_ARREADY;

    // write completes when the second of aw/w lands
    assign wr_fire = ((state_q == IDLE) & aw_take & w_take)
                   | ((state_q == GOT_AW) & w_take)
                   | ((state_q == GOT_W) & aw_take);

    // live channel value, else the one held from earlier
    assign wr_addr = aw_take ? S_AXI_AWADDR : aw_addr_q;
    assign wr_data = w_take ? S_AXI_WDATA : w_data_q;
    assign wr_strb = w_take ? S_AXI_WSTRB : w_strb_q;

    // fsm
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state_q <= RESP_B;
                    end else if (S_AXI_AWVALID) begin
                        state_q <= GOT_AW;
                    end else if (S_AXI_WVALID) begin
                        state_q <= GOT_W;
                    end else if (S_AXI_ARVALID) begin
                        state_q <= READ_1;
                    end
                end
                GOT_AW: begin
                    if (S_AXI_WVALID) begin
                        state_q <= RESP_B;
                    end
                end
                GOT_W: begin
                    if (S_AXI_AWVALID) begin
                        state_q <= RESP_B;
                    end
                end
                RESP_B: begin
                    if (S_AXI_BREADY) begin
                        state_q <= IDLE;
                    end
                end
                // one cycle to fetch rdata
                READ_1: state_q <= READ_2;
                READ_2: begin
                    if (S_AXI_RREADY) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // held address and data
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_take) begin
            aw_addr_q <= S_AXI_AWADDR;
        end
        if (w_take) begin
            w_data_q <= S_AXI_WDATA;
            w_strb_q <= S_AXI_WSTRB;
        end
        if (ar_take) begin
            ar_addr_q <= S_AXI_ARADDR;
        end
    end

    // ====================
    // registers
    // ====================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run      <= 1'b0;
            gen      <= 1'b0;
            item_sel <= '0;
        end else begin
            // bus write beats the generator's clear
            if (wr_fire && wr_addr == REG_CTRL && wr_strb[0]) begin
                run <= wr_data[1];
                gen <= wr_data[0];
            end else if (gen_done) begin
                gen <= 1'b0;
            end
            if (wr_fire && wr_addr == REG_ITEM_SEL) begin
                if (wr_strb[0]) begin
                    item_sel[7:0] <= wr_data[7:0];
                end
                if (wr_strb[1]) begin
                    item_sel[15:8] <= wr_data[15:8];
                end
            end
        end
    end

    // read mux, unmapped offsets give 0
    always_comb begin
        case (ar_addr_q)
            REG_CTRL:     rd_word = {30'd0, run, gen};
            REG_ITEM_SEL: rd_word = {16'd0, item_sel};
            default:      rd_word = '0;
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (state_q == READ_1) begin
            S_AXI_RDATA <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* hdl/item_memory_gen.sv */
`include "hdc_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module item_memory_gen (
    input  wire                AXIS_ACLK,
    input  wire                S_AXI_ARESETN,
    input  wire                gen,
    input  hdc_pkg::item_idx_t item_sel,
    output logic               gen_done,
    output hdc_pkg::hv_t       key
);

    import hdc_pkg::*;

    logic [31:0] state_q;
    logic [31:0] state_nxt;
    item_idx_t   idx_q;

    // 13 / 17 / 5 variant
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign state_nxt = xorshift32(state_q);

    // item idx_q is the output being produced this cycle
    assign gen_done = gen & (idx_q == item_sel);

    // prng and index, parked at seed while gen is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            state_q <= `HDC_SEED;
            idx_q   <= '0;
        end else begin
            state_q <= state_nxt;
            idx_q   <= idx_q + 1'b1;
        end
    end

    // key kept until the next match
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            key <= '0;
        end else if (gen_done) begin
            key <= state_nxt;
        end
    end

endmodule

`default_nettype wire

/* hdl/hv_pipe_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module hv_pipe_reg #(
    parameter type T = logic
) (
    input  wire      AXIS_ACLK,
    input  wire      S_AXI_ARESETN,
    input  wire      flush,
    hv_stream_if.dst in,
    hv_stream_if.src out
);

    logic valid_q;
    logic last_q;
    T     data_q;
    logic take;

    // room when empty or when the held beat leaves now
    assign in.ready = ~flush & (~valid_q | out.ready);
    assign take     = in.valid & in.ready;

    assign out.valid = valid_q;
    assign out.data  = data_q;
    assign out.last  = last_q;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || flush) begin
            valid_q <= 1'b0;
        end else if (in.ready) begin
            // refill or drain
            valid_q <= in.valid;
        end
    end

    // payload only moves on an accepted beat
    always_ff @(posedge AXIS_ACLK) begin
        if (take) begin
            data_q <= in.data;
            last_q <= in.last;
        end
    end

endmodule

`default_nettype wire

/* hdl/hv_bundler.sv */
`include "hdc_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module hv_bundler (
    input  wire hdc_pkg::hv_t key,
    hv_stream_if.dst          in,
    hv_stream_if.src          out
);

    import hdc_pkg::*;

    localparam int CW = $clog2(`HDC_LANES + 1);

    hv_t maj;

    // per bit: bind each lane with the key, count ones, majority vote
    always_comb begin
        logic [CW-1:0] ones;
        ones = '0;
        for (int b = 0; b < `HDC_DIM; b++) begin
            ones = '0;
            for (int l = 0; l < `HDC_LANES; l++) begin
                ones = ones + CW'(in.data[l][b] ^ key[b]);
            end
            if (2 * int'(ones) > `HDC_LANES) begin
                maj[b] = 1'b1;
            end else if (2 * int'(ones) < `HDC_LANES) begin
                maj[b] = 1'b0;
            end else begin
                // even split, fall back to key
                maj[b] = key[b];
            end
        end
    end

    // handshake straight through
    assign out.valid = in.valid;
    assign out.data  = maj;
    assign out.last  = in.last;
    assign in.ready  = out.ready;

endmodule

`default_nettype wire

/* hdl/hdc_top.sv */
`include "hdc_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module hdc_top (
    input  wire                            AXIS_ACLK,
    input  wire                            S_AXI_ARESETN,
    // axi-lite slave
    input  wire [`HDC_AXIL_AW-1:0]         S_AXI_AWADDR,
    input  wire                            S_AXI_AWVALID,
    output logic                           S_AXI_AWREADY,
    input  wire [31:0]                     S_AXI_WDATA,
    input  wire [3:0]                      S_AXI_WSTRB,
    input  wire                            S_AXI_WVALID,
    output logic                           S_AXI_WREADY,
    output logic [1:0]                     S_AXI_BRESP,
    output logic                           S_AXI_BVALID,
    input  wire                            S_AXI_BREADY,
    input  wire [`HDC_AXIL_AW-1:0]         S_AXI_ARADDR,
    input  wire                            S_AXI_ARVALID,
    output logic                           S_AXI_ARREADY,
    output logic [31:0]                    S_AXI_RDATA,
    output logic [1:0]                     S_AXI_RRESP,
    output logic                           S_AXI_RVALID,
    input  wire                            S_AXI_RREADY,
    // axi-stream slave, lane i in bits 32i+31..32i
    input  wire                            S_AXIS_TVALID,
    output logic                           S_AXIS_TREADY,
    input  wire [`HDC_LANES*`HDC_DIM-1:0]  S_AXIS_TDATA,
    input  wire                            S_AXIS_TLAST,
    // axi-stream master
    output logic                           M_AXIS_TVALID,
    input  wire                            M_AXIS_TREADY,
    output logic [`HDC_DIM-1:0]            M_AXIS_TDATA,
    output logic                           M_AXIS_TLAST
);

    import hdc_pkg::*;

    logic      run;
    logic      gen;
    logic      gen_done;
    item_idx_t item_sel;
    hv_t       key;

    hv_stream_if #(.T(lanes_t)) s_axis ();
    hv_stream_if #(.T(lanes_t)) s_bound ();
    hv_stream_if #(.T(hv_t))    s_bundled ();
    hv_stream_if #(.T(hv_t))    m_axis ();

    // always OKAY
    assign S_AXI_BRESP = 2'b00;
    assign S_AXI_RRESP = 2'b00;

    // ====================
    // control
    // ====================

    axil_regs u_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .gen_done      (gen_done),
        .run           (run),
        .gen           (gen),
        .item_sel      (item_sel)
    );

    item_memory_gen u_item_mem (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_sel      (item_sel),
        .gen_done      (gen_done),
        .key           (key)
    );

    // ====================
    // stream path
    // ====================

    // port to interface
    assign s_axis.valid  = S_AXIS_TVALID;
    assign s_axis.data   = S_AXIS_TDATA;
    assign s_axis.last   = S_AXIS_TLAST;
    assign S_AXIS_TREADY = s_axis.ready;

    assign M_AXIS_TVALID = m_axis.valid;
    assign M_AXIS_TDATA  = m_axis.data;
    assign M_AXIS_TLAST  = m_axis.last;
    assign m_axis.ready  = M_AXIS_TREADY;

    // both stages drop their beats while stopped
    hv_pipe_reg #(.T(lanes_t)) in_stage (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .flush         (~run),
        .in            (s_axis),
        .out           (s_bound)
    );

    hv_bundler u_bundler (
        .key (key),
        .in  (s_bound),
        .out (s_bundled)
    );

    hv_pipe_reg #(.T(hv_t)) out_stage (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .flush         (~run),
        .in            (s_bundled),
        .out           (m_axis)
    );

endmodule

`default_nettype wire

/* dv/hdc_checker.sv */
`include "hdc_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module hdc_checker (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            run,
    input  wire                            ready_high,
    input  hdc_pkg::item_idx_t             item_sel,
    input  wire                            s_valid,
    input  wire                            s_ready,
    input  wire [`HDC_LANES*`HDC_DIM-1:0]  s_data,
    input  wire                            s_last,
    input  wire                            m_valid,
    input  wire                            m_ready,
    input  hdc_pkg::hv_t                   m_data,
    input  wire                            m_last,
    output int                             errors,
    output int                             beats,
    output int                             pending
);

    import hdc_pkg::*;

    int   stream_errs = 0;
    int   note_errs = 0;
    int   cycle = 0;
    hv_t  exp_data_q[$];
    logic exp_last_q[$];
    int   accept_q[$];

    assign errors  = stream_errs + note_errs;
    assign pending = exp_data_q.size();

    // one xorshift32 step, shifts 13 / 17 / 5
    function automatic logic [31:0] xs_step(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // item k is the (k+1)-th output after the seed
    function automatic hv_t model_key(input item_idx_t idx);
        logic [31:0] s;
        s = `HDC_SEED;
        for (int k = 0; k <= int'(idx); k++) begin
            s = xs_step(s);
        end
        return s;
    endfunction

    // majority of the bound lanes, ties go to the key bit
    function automatic hv_t model_bundle(input logic [`HDC_LANES*`HDC_DIM-1:0] d,
                                         input hv_t k);
        hv_t r;
        int  n;
        for (int b = 0; b < `HDC_DIM; b++) begin
            n = 0;
            for (int l = 0; l < `HDC_LANES; l++) begin
                n = n + int'(d[`HDC_DIM*l + b] ^ k[b]);
            end
            if (2 * n > `HDC_LANES) begin
                r[b] = 1'b1;
            end else if (2 * n < `HDC_LANES) begin
                r[b] = 1'b0;
            end else begin
                r[b] = k[b];
            end
        end
        return r;
    endfunction

    // register readback compare, called from the testbench
    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            note_errs++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        note_errs++;
    endtask

    // ====================
    // stream scoreboard
    // ====================

    always @(posedge clk) begin
        if (rst_n) begin
            cycle <= cycle + 1;
            if (s_valid && s_ready) begin
                if (!run) begin
                    $display("Error at %0t: input beat accepted while run is low", $time);
                    stream_errs++;
                end
                exp_data_q.push_back(model_bundle(s_data, model_key(item_sel)));
                exp_last_q.push_back(s_last);
                accept_q.push_back(cycle);
            end
            if (m_valid && m_ready) begin
                beats <= beats + 1;
                if (!run) begin
                    $display("Error at %0t: output beat sent while run is low", $time);
                    stream_errs++;
                end
                if (exp_data_q.size() == 0) begin
                    $display("Error at %0t: output beat with no input pending", $time);
                    stream_errs++;
                end else begin
                    hv_t  ed;
                    logic el;
                    int   ta;
                    ed = exp_data_q.pop_front();
                    el = exp_last_q.pop_front();
                    ta = accept_q.pop_front();
                    if (m_data !== ed) begin
                        $display("Mismatch at %0t: M_AXIS_TDATA got %h expected %h",
                                 $time, m_data, ed);
                        stream_errs++;
                    end
                    if (m_last !== el) begin
                        $display("Mismatch at %0t: M_AXIS_TLAST got %b expected %b",
                                 $time, m_last, el);
                        stream_errs++;
                    end
                    // two edges from acceptance to output with ready held
                    if (ready_high && (cycle - ta) != 2) begin
                        $display("Mismatch at %0t: beat latency got %0d expected 2",
                                 $time, cycle - ta);
                        stream_errs++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/hdc_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module hdc_assertions (
    input wire        clk,
    input wire        rst_n,
    input wire        run,
    input wire        bvalid,
    input wire        bready,
    input wire        rvalid,
    input wire        rready,
    input wire [31:0] rdata,
    input wire        s_tready,
    input wire        m_valid,
    input wire        m_ready,
    input wire [31:0] m_data,
    input wire        m_last
);

    // output beat held until taken, unless flushed
    a_m_hold: assert property (@(posedge clk) disable iff (!rst_n || !run)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
        else $error("M_AXIS beat changed before transfer");

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("BVALID dropped before BREADY");

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("RVALID or RDATA changed before RREADY");

    // stopped stream takes nothing
    a_stop: assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> !s_tready)
        else $error("S_AXIS_TREADY high while run is low");

endmodule

`default_nettype wire

/* dv/hdc_tb.sv */
`include "hdc_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module hdc_tb;

    import hdc_pkg::*;
    import axil_pkg::*;

    localparam int TBL_LEN    = 8;
    localparam int POLL_LIMIT = 40;
    localparam int WATCHDOG   = (200 + 20 * TBL_LEN) * 2;

    logic                           clk = 1'b0;
    logic                           rst_n = 1'b0;
    logic [`HDC_AXIL_AW-1:0]        awaddr = '0;
    logic                           awvalid = 1'b0;
    logic [31:0]                    wdata = '0;
    logic [3:0]                     wstrb = '0;
    logic                           wvalid = 1'b0;
    logic                           bready = 1'b0;
    logic [`HDC_AXIL_AW-1:0]        araddr = '0;
    logic                           arvalid = 1'b0;
    logic                           rready = 1'b0;
    logic                           s_valid = 1'b0;
    logic [`HDC_LANES*`HDC_DIM-1:0] s_data = '0;
    logic                           s_last = 1'b0;
    logic                           m_ready = 1'b1;
    logic                           ready_high = 1'b1;
    item_idx_t                      cur_item = '0;

    wire        awready;
    wire        wready;
    wire [1:0]  bresp;
    wire        bvalid;
    wire        arready;
    wire [31:0] rdata;
    wire [1:0]  rresp;
    wire        rvalid;
    wire        s_ready;
    wire        m_valid;
    wire [31:0] m_data;
    wire        m_last;
    int         errors;
    int         beats;
    int         pending;

    // stimulus table, four lanes and a last flag per entry
    logic [31:0] tbl_lane [TBL_LEN][`HDC_LANES];
    logic        tbl_last [TBL_LEN];
    logic [31:0] rd;

    always #2 clk = ~clk;

    hdc_top uut (
        .AXIS_ACLK(clk), .S_AXI_ARESETN(rst_n),
        .S_AXI_AWADDR(awaddr), .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
        .S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb), .S_AXI_WVALID(wvalid),
        .S_AXI_WREADY(wready), .S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid),
        .S_AXI_BREADY(bready), .S_AXI_ARADDR(araddr), .S_AXI_ARVALID(arvalid),
        .S_AXI_ARREADY(arready), .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
        .S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
        .S_AXIS_TVALID(s_valid), .S_AXIS_TREADY(s_ready),
        .S_AXIS_TDATA(s_data), .S_AXIS_TLAST(s_last),
        .M_AXIS_TVALID(m_valid), .M_AXIS_TREADY(m_ready),
        .M_AXIS_TDATA(m_data), .M_AXIS_TLAST(m_last)
    );

    hdc_checker chk (
        .clk(clk), .rst_n(rst_n), .run(uut.run), .ready_high(ready_high),
        .item_sel(cur_item), .s_valid(s_valid), .s_ready(s_ready),
        .s_data(s_data), .s_last(s_last), .m_valid(m_valid), .m_ready(m_ready),
        .m_data(m_data), .m_last(m_last), .errors(errors), .beats(beats),
        .pending(pending)
    );

    bind hdc_top hdc_assertions asrt (
        .clk(AXIS_ACLK), .rst_n(S_AXI_ARESETN), .run(run),
        .bvalid(S_AXI_BVALID), .bready(S_AXI_BREADY), .rvalid(S_AXI_RVALID),
        .rready(S_AXI_RREADY), .rdata(S_AXI_RDATA), .s_tready(S_AXIS_TREADY),
        .m_valid(M_AXIS_TVALID), .m_ready(M_AXIS_TREADY), .m_data(M_AXIS_TDATA),
        .m_last(M_AXIS_TLAST)
    );

    // ====================
    // bus tasks
    // ====================

    task automatic axil_write(input logic [`HDC_AXIL_AW-1:0] a, input logic [31:0] d);
        @(posedge clk);
        awaddr  <= a;
        awvalid <= 1'b1;
        wdata   <= d;
        wstrb   <= 4'hf;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!bvalid);
        // response waits one cycle before it is taken
        bready <= 1'b1;
        @(posedge clk);
        chk.expect_word("S_AXI_BRESP", {30'd0, bresp}, 32'h0);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [`HDC_AXIL_AW-1:0] a, output logic [31:0] d);
        @(posedge clk);
        araddr  <= a;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        // hold off rready for a cycle
        rready <= 1'b1;
        @(posedge clk);
        d = rdata;
        chk.expect_word("S_AXI_RRESP", {30'd0, rresp}, 32'h0);
        rready <= 1'b0;
    endtask

    // select an item, start the generator, poll until gen clears
    task automatic make_key(input item_idx_t idx);
        int n;
        cur_item <= idx;
        axil_write(REG_ITEM_SEL, {16'd0, idx});
        axil_write(REG_CTRL, 32'h1);
        for (n = 0; n < POLL_LIMIT; n++) begin
            axil_read(REG_CTRL, rd);
            if (rd[0] == 1'b0) begin
                break;
            end
        end
        if (n == POLL_LIMIT) begin
            chk.note_failure("gen did not clear within the poll limit");
        end
    endtask

    // whole table through the stream, sink ready random or held high
    task automatic stream_pass(input bit rand_ready);
        int target;
        target = beats + TBL_LEN;
        ready_high <= !rand_ready;
        fork
            begin
                @(posedge clk);
                for (int i = 0; i < TBL_LEN; i++) begin
                    s_valid <= 1'b1;
                    s_data  <= {tbl_lane[i][3], tbl_lane[i][2], tbl_lane[i][1], tbl_lane[i][0]};
                    s_last  <= tbl_last[i];
                    do @(posedge clk); while (!s_ready);
                end
                s_valid <= 1'b0;
            end
            begin
                while (beats < target) begin
                    @(posedge clk);
                    m_ready <= rand_ready ? 1'($urandom & 1) : 1'b1;
                end
                m_ready <= 1'b1;
            end
        join
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(32'h821d));
        for (int i = 0; i < TBL_LEN; i++) begin
            for (int l = 0; l < `HDC_LANES; l++) begin
                tbl_lane[i][l] = $urandom;
            end
            tbl_last[i] = (i % 4) == 3;
        end
        // tie on every bit, output equals key
        a = $urandom;
        b = $urandom;
        tbl_lane[4] = '{a, a, ~a, ~a};
        tbl_lane[5] = '{a, ~a, b, ~b};
        tbl_lane[6] = '{32'hffff_ffff, 32'h0, 32'h0, 32'h0};

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        axil_read(REG_CTRL, rd);
        chk.expect_word("REG_CTRL", rd, 32'h0);
        axil_read(REG_ITEM_SEL, rd);
        chk.expect_word("REG_ITEM_SEL", rd, 32'h0);
        axil_write(REG_ITEM_SEL, 32'habcd_1234);
        axil_read(REG_ITEM_SEL, rd);
        chk.expect_word("REG_ITEM_SEL", rd, 32'h0000_1234);

        make_key(16'd5);
        axil_write(REG_CTRL, 32'h2);
        stream_pass(1'b0);
        stream_pass(1'b1);

        // stopped stream: offer beats, none may pass
        axil_write(REG_CTRL, 32'h0);
        @(posedge clk);
        s_valid <= 1'b1;
        repeat (12) @(posedge clk);
        s_valid <= 1'b0;

        make_key(16'd0);
        axil_write(REG_CTRL, 32'h2);
        stream_pass(1'b0);

        if (pending != 0) begin
            chk.note_failure("input beats never reached the output");
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d, beats: %0d", errors, beats);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: stream did not complete");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hdl
hdl/hdc_pkg.sv
hdl/axil_pkg.sv
hdl/hv_stream_if.sv
hdl/axil_regs.sv
hdl/item_memory_gen.sv
hdl/hv_pipe_reg.sv
hdl/hv_bundler.sv
hdl/hdc_top.sv
dv/hdc_checker.sv
dv/hdc_assertions.sv
dv/hdc_tb.sv

/* Makefile */
TOP := hdc_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
